/* Bender.yml */
package:
  name: vec_alu

export_include_dirs:
  - include

sources:
  - files:
      - logic/vec_alu_pkg.sv
      - logic/lane_if.sv
      - logic/carry_lookahead.sv
      - logic/op_dispatch.sv
      - logic/lane_alu.sv
      - logic/result_collect.sv
      - logic/vec_alu_top.sv
  - target: test
    files:
      - tests/vec_alu_assertions.sv
      - tests/vec_alu_tb.sv

/* include/vec_alu_params.svh */
`ifndef VEC_ALU_PARAMS_SVH
`define VEC_ALU_PARAMS_SVH

// number of parallel lanes in one request
`define VA_LANES 4

// bits per lane operand and result
`define VA_DATA_WIDTH 16

`endif

/* logic/carry_lookahead.sv */
`default_nettype none

module carry_lookahead #(
   parameter int DATA_WIDTH = 16
) (
   input  logic [DATA_WIDTH-1:0] op1_i,
   input  logic [DATA_WIDTH-1:0] op2_i,
   input  logic                  add_op_i,
   output logic [DATA_WIDTH-1:0] res_o,
   output logic                  cout_o
);

   // per-bit generate and propagate
   logic [DATA_WIDTH-1:0] g;
   logic [DATA_WIDTH-1:0] p;
   // second operand after optional inversion
   logic [DATA_WIDTH-1:0] op2_x;
   // carry chain, c[0] is the carry in
   logic [DATA_WIDTH:0]   c;

   // subtract is a + ~b + 1
   assign op2_x = add_op_i ? op2_i : ~op2_i;
   assign c[0]  = ~add_op_i;

   genvar i;
   generate
      for (i = 0; i < DATA_WIDTH; i = i + 1) begin : g_bit
         assign g[i]     = op1_i[i] & op2_x[i];
         assign p[i]     = op1_i[i] ^ op2_x[i];
         // carry into the next bit
         assign c[i + 1] = g[i] | (p[i] & c[i]);
         assign res_o[i] = p[i] ^ c[i];
      end
   endgenerate

   // on subtract a set carry means no borrow, so a >= b
   assign cout_o = c[DATA_WIDTH];

endmodule

`default_nettype wire

/* logic/lane_alu.sv */
`default_nettype none

`include "vec_alu_params.svh"

module lane_alu (
   input  logic     clk_i,
   input  logic     rst_i,
   lane_req_if.lane req_i,
   lane_rsp_if.lane rsp_o
);
   import vec_alu_pkg::*;

   // raw adder output
   lane_word_t sum;
   logic       cout;
   // selected result and its zero flag
   lane_word_t res_d;
   logic       zero_d;

   carry_lookahead #(
      .DATA_WIDTH (`VA_DATA_WIDTH)
   ) u_cla (
      .op1_i    (req_i.a),
      .op2_i    (req_i.b),
      .add_op_i (~req_i.sub_en),
      .res_o    (sum),
      .cout_o   (cout)
   );

   always_comb begin
      case (req_i.sel)
         SEL_SUM: res_d = sum;
         // borrow on a - b means a < b
         SEL_LT:  res_d = {{(`VA_DATA_WIDTH-1){1'b0}}, ~cout};
         // zero difference means a == b
         SEL_EQ:  res_d = {{(`VA_DATA_WIDTH-1){1'b0}}, (sum == '0)};
         default: res_d = sum;
      endcase
   end

   assign zero_d = (res_d == '0);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rsp_o.valid <= 1'b0;
      end else begin
         rsp_o.valid <= req_i.valid;
      end
   end

   // response payload
   always_ff @(posedge clk_i) begin
      rsp_o.active <= req_i.active;
      rsp_o.res    <= res_d;
      rsp_o.carry  <= cout;
      rsp_o.zero   <= zero_d;
   end

endmodule

`default_nettype wire

/* logic/lane_if.sv */
`default_nettype none

// dispatcher to lane request, one per lane
interface lane_req_if;
   import vec_alu_pkg::*;

   logic       valid;
   // lane is unmasked
   logic       active;
   // subtract instead of add
   logic       sub_en;
   res_sel_e   sel;
   lane_word_t a;
   lane_word_t b;

   modport disp (output valid, active, sub_en, sel, a, b);
   modport lane (input  valid, active, sub_en, sel, a, b);

endinterface

// lane to collector response, one per lane
interface lane_rsp_if;
   import vec_alu_pkg::*;

   logic       valid;
   logic       active;
   lane_word_t res;
   // adder carry out, no borrow on subtract
   logic       carry;
   // chosen result is all zero
   logic       zero;

   modport lane (output valid, active, res, carry, zero);
   modport coll (input  valid, active, res, carry, zero);

endinterface

`default_nettype wire

/* logic/op_dispatch.sv */
`default_nettype none

`include "vec_alu_params.svh"

module op_dispatch (
   input  logic                                     clk_i,
   input  logic                                     rst_i,
   input  logic                                     valid_i,
   input  vec_alu_pkg::alu_op_e                     op_i,
   input  logic [`VA_LANES*`VA_DATA_WIDTH-1:0]      a_i,
   input  logic [`VA_LANES*`VA_DATA_WIDTH-1:0]      b_i,
   input  logic [`VA_LANES-1:0]                     mask_i,
   input  logic                                     bcast_i,
   lane_req_if.disp                                 req_o [`VA_LANES]
);
   import vec_alu_pkg::*;

   // decoded opcode, shared by all lanes
   logic     sub_en_d;
   res_sel_e sel_d;

   always_comb begin
      sub_en_d = 1'b1;
      sel_d    = SEL_SUM;
      case (op_i)
         OP_ADD: begin
            sub_en_d = 1'b0;
            sel_d    = SEL_SUM;
         end
         OP_SUB: begin
            sel_d = SEL_SUM;
         end
         // less-than comes from the borrow of a - b
         OP_SLTU: begin
            sel_d = SEL_LT;
         end
         // equality checks the difference for zero
         OP_SEQ: begin
            sel_d = SEL_EQ;
         end
         default: begin
            sub_en_d = 1'b0;
         end
      endcase
   end

   genvar i;
   generate
      for (i = 0; i < `VA_LANES; i = i + 1) begin : g_lane
         lane_word_t b_sel;

         // broadcast copies lane 0 of b to every lane
         assign b_sel = bcast_i ? b_i[`VA_DATA_WIDTH-1:0]
                                : b_i[i*`VA_DATA_WIDTH +: `VA_DATA_WIDTH];

         always_ff @(posedge clk_i) begin
            if (rst_i) begin
               req_o[i].valid <= 1'b0;
            end else begin
               req_o[i].valid <= valid_i;
            end
         end

         // lane operands and decoded controls
         always_ff @(posedge clk_i) begin
            req_o[i].active <= mask_i[i];
            req_o[i].sub_en <= sub_en_d;
            req_o[i].sel    <= sel_d;
            req_o[i].a      <= a_i[i*`VA_DATA_WIDTH +: `VA_DATA_WIDTH];
            req_o[i].b      <= b_sel;
         end
      end
   endgenerate

endmodule

`default_nettype wire

/* logic/result_collect.sv */
`default_nettype none

`include "vec_alu_params.svh"

module result_collect (
   input  logic                                clk_i,
   input  logic                                rst_i,
   lane_rsp_if.coll                            rsp_i [`VA_LANES],
   output logic                                valid_o,
   output logic [`VA_LANES*`VA_DATA_WIDTH-1:0] res_o,
   output logic [`VA_LANES-1:0]                carry_o,
   output logic [`VA_LANES-1:0]                zero_o
);

   // packed next-state values, one slice per lane
   wire [`VA_LANES*`VA_DATA_WIDTH-1:0] res_d;
   wire [`VA_LANES-1:0]                carry_d;
   wire [`VA_LANES-1:0]                zero_d;
   // lane holds a live, unmasked result
   wire [`VA_LANES-1:0]                keep;

   genvar i;
   generate
      for (i = 0; i < `VA_LANES; i = i + 1) begin : g_lane
         assign keep[i] = rsp_i[i].valid & rsp_i[i].active;
         // masked or idle lanes read as zero
         assign res_d[i*`VA_DATA_WIDTH +: `VA_DATA_WIDTH] =
            keep[i] ? rsp_i[i].res : '0;
         assign carry_d[i] = keep[i] & rsp_i[i].carry;
         assign zero_d[i]  = keep[i] & rsp_i[i].zero;
      end
   endgenerate

   // all lanes move in lockstep, lane 0 stands for the vector
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_o <= 1'b0;
         res_o   <= '0;
         carry_o <= '0;
         zero_o  <= '0;
      end else begin
         valid_o <= rsp_i[0].valid;
         res_o   <= res_d;
         carry_o <= carry_d;
         zero_o  <= zero_d;
      end
   end

endmodule

`default_nettype wire

/* logic/vec_alu_pkg.sv */
`default_nettype none

`include "vec_alu_params.svh"

package vec_alu_pkg;

   // request opcodes, all unsigned
   typedef enum logic [1:0] {
      OP_ADD  = 2'b00,
      OP_SUB  = 2'b01,
      OP_SLTU = 2'b10,
      OP_SEQ  = 2'b11
   } alu_op_e;

   // lane result source chosen by the dispatcher
   typedef enum logic [1:0] {
      SEL_SUM = 2'b00,
      SEL_LT  = 2'b01,
      SEL_EQ  = 2'b10
   } res_sel_e;

   // one lane operand or result
   typedef logic [`VA_DATA_WIDTH-1:0] lane_word_t;

endpackage

`default_nettype wire

/* logic/vec_alu_top.sv */
`default_nettype none

`include "vec_alu_params.svh"

module vec_alu_top (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic                                valid_i,
   input  vec_alu_pkg::alu_op_e                op_i,
   input  logic [`VA_LANES*`VA_DATA_WIDTH-1:0] a_i,
   input  logic [`VA_LANES*`VA_DATA_WIDTH-1:0] b_i,
   input  logic [`VA_LANES-1:0]                mask_i,
   input  logic                                bcast_i,
   output logic                                valid_o,
   output logic [`VA_LANES*`VA_DATA_WIDTH-1:0] res_o,
   output logic [`VA_LANES-1:0]                carry_o,
   output logic [`VA_LANES-1:0]                zero_o
);

   // one request and one response link per lane
   lane_req_if req_if [`VA_LANES] ();
   lane_rsp_if rsp_if [`VA_LANES] ();

   // stage 1, decode and slice
   op_dispatch u_disp (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (valid_i),
      .op_i    (op_i),
      .a_i     (a_i),
      .b_i     (b_i),
      .mask_i  (mask_i),
      .bcast_i (bcast_i),
      .req_o   (req_if)
   );

   // stage 2, identical lanes
   genvar i;
   generate
      for (i = 0; i < `VA_LANES; i = i + 1) begin : g_lane
         lane_alu u_lane (
            .clk_i (clk_i),
            .rst_i (rst_i),
            .req_i (req_if[i]),
            .rsp_o (rsp_if[i])
         );
      end
   endgenerate

   // stage 3, pack and mask
   result_collect u_coll (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .rsp_i   (rsp_if),
      .valid_o (valid_o),
      .res_o   (res_o),
      .carry_o (carry_o),
      .zero_o  (zero_o)
   );

endmodule

`default_nettype wire

/* src.f */
+incdir+include
logic/vec_alu_pkg.sv
logic/lane_if.sv
logic/carry_lookahead.sv
logic/op_dispatch.sv
logic/lane_alu.sv
logic/result_collect.sv
logic/vec_alu_top.sv
tests/vec_alu_assertions.sv
tests/vec_alu_tb.sv

/* tests/vec_alu_assertions.sv */
`default_nettype none

`include "vec_alu_params.svh"

module vec_alu_assertions (
   input logic                 clk_i,
   input logic                 rst_i,
   input logic                 valid_i,
   input logic                 out_valid_i,
   input logic [`VA_LANES-1:0] carry_i,
   input logic [`VA_LANES-1:0] zero_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // three register stages from request to result
   a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
      valid_i |-> ##3 out_valid_i)
      else $error("valid_o missing three cycles after valid_i");

   // one reset edge clears the output valid
   a_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_i)
      else $error("valid_o high after a reset edge");

   // idle cycles carry no flags
   a_flags: assert property (@(posedge clk_i) disable iff (rst_i)
      !out_valid_i |-> (carry_i == '0) && (zero_i == '0))
      else $error("carry_o or zero_o set while valid_o is low");

endmodule

bind vec_alu_top vec_alu_assertions u_assert (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .valid_i     (valid_i),
   .out_valid_i (valid_o),
   .carry_i     (carry_o),
   .zero_i      (zero_o)
);

`default_nettype wire

/* tests/vec_alu_tb.sv */
`default_nettype none

`include "vec_alu_params.svh"

module vec_alu_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import vec_alu_pkg::*;

   localparam int LANES = `VA_LANES;
   localparam int DW = `VA_DATA_WIDTH;
   localparam int VW = LANES * DW;
   // expected word packs {res, carry, zero}
   localparam int EW = VW + 2 * LANES;
   localparam int N_DIR = 8;
   localparam int N_CMP = 20;
   localparam int N_MASK = 12;
   localparam int N_BC = 8;
   localparam int N_B2B = 40;
   localparam int N_REQ = N_DIR + N_CMP + N_MASK + N_BC + N_B2B;
   // reset, gaps after each test, up to 3 idle cycles after each b2b request
   localparam int N_SLACK = 4 + 5 * 4 + 3 * N_B2B;
   localparam int LIMIT_CYC = N_REQ + N_SLACK + 20;

   logic             clk;
   logic             rst;
   logic             in_valid;
   alu_op_e          op;
   logic [VW-1:0]    a_vec;
   logic [VW-1:0]    b_vec;
   logic [LANES-1:0] mask;
   logic             bcast;
   logic             out_valid;
   logic [VW-1:0]    res;
   logic [LANES-1:0] carry;
   logic [LANES-1:0] zero;

   // pending requests in issue order
   logic [EW-1:0] exp_q [$];
   int            due_q [$];
   string         name_q [$];
   // cycle count and reset as seen by the DUT at the last edge
   int            cyc;
   logic          rst_q;
   int            res_errs;
   int            carry_errs;
   int            zero_errs;
   int            timing_errs;
   lane_word_t    corner [4];

   vec_alu_top dut (
      .clk_i   (clk),
      .rst_i   (rst),
      .valid_i (in_valid),
      .op_i    (op),
      .a_i     (a_vec),
      .b_i     (b_vec),
      .mask_i  (mask),
      .bcast_i (bcast),
      .valid_o (out_valid),
      .res_o   (res),
      .carry_o (carry),
      .zero_o  (zero)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cyc   <= cyc + 1;
      rst_q <= rst;
   end

   // plain unsigned arithmetic per lane with inactive lanes read as zero
   function automatic logic [EW-1:0] ref_result(input alu_op_e f_op,
         input logic [VW-1:0] f_a, input logic [VW-1:0] f_b,
         input logic [LANES-1:0] f_mask, input logic f_bcast);
      logic [VW-1:0]    r_vec;
      logic [LANES-1:0] c_vec;
      logic [LANES-1:0] z_vec;
      lane_word_t       av;
      lane_word_t       bv;
      lane_word_t       r;
      logic [DW:0]      wide;
      int               l;
      r_vec = '0;
      c_vec = '0;
      z_vec = '0;
      for (l = 0; l < LANES; l++) begin
         av = f_a[l*DW +: DW];
         bv = f_bcast ? f_b[DW-1:0] : f_b[l*DW +: DW];
         wide = {1'b0, av} + {1'b0, bv};
         case (f_op)
            OP_ADD:  r = wide[DW-1:0];
            OP_SUB:  r = av - bv;
            OP_SLTU: r = (av < bv) ? lane_word_t'(1) : '0;
            default: r = (av == bv) ? lane_word_t'(1) : '0;
         endcase
         if (f_mask[l]) begin
            r_vec[l*DW +: DW] = r;
            // add overflow, or no borrow for the subtract-based ops
            c_vec[l] = (f_op == OP_ADD) ? wide[DW] : (av >= bv);
            z_vec[l] = (r == '0);
         end
      end
      return {r_vec, c_vec, z_vec};
   endfunction

   function automatic logic [VW-1:0] rand_vec();
      logic [VW-1:0] v;
      int            l;
      for (l = 0; l < LANES; l++) begin
         v[l*DW +: DW] = lane_word_t'($urandom);
      end
      return v;
   endfunction

   // one request on the next falling edge, with its expected response
   task automatic send(input string t_name, input alu_op_e t_op,
         input logic [VW-1:0] t_a, input logic [VW-1:0] t_b,
         input logic [LANES-1:0] t_mask, input logic t_bcast);
      @(negedge clk);
      in_valid = 1'b1;
      op       = t_op;
      a_vec    = t_a;
      b_vec    = t_b;
      mask     = t_mask;
      bcast    = t_bcast;
      exp_q.push_back(ref_result(t_op, t_a, t_b, t_mask, t_bcast));
      // three register stages put the result at the third falling edge from here
      due_q.push_back(cyc + 3);
      name_q.push_back(t_name);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         in_valid = 1'b0;
      end
   endtask

   initial begin
      logic [VW-1:0]    ta;
      logic [VW-1:0]    tb;
      logic [LANES-1:0] eq_lanes;
      int               i;
      int               j;
      int               l;
      int               total;
      void'($urandom(32));
      clk         = 1'b0;
      rst         = 1'b1;
      rst_q       = 1'b1;
      in_valid    = 1'b0;
      op          = OP_ADD;
      a_vec       = '0;
      b_vec       = '0;
      mask        = '0;
      bcast       = 1'b0;
      cyc         = 0;
      res_errs    = 0;
      carry_errs  = 0;
      zero_errs   = 0;
      timing_errs = 0;
      // zero, all ones, one and the top bit
      corner[0] = '0;
      corner[1] = '1;
      corner[2] = lane_word_t'(1);
      corner[3] = lane_word_t'(1) << (DW - 1);
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // every corner pair for add and subtract including equal pairs
      for (i = 0; i < 2; i++) begin
         for (j = 0; j < 4; j++) begin
            for (l = 0; l < LANES; l++) begin
               ta[l*DW +: DW] = corner[j];
               tb[l*DW +: DW] = corner[l % 4];
            end
            send("add_sub_corner", alu_op_e'(i), ta, tb, '1, 1'b0);
         end
      end
      idle(4);

      // compares with some lanes forced equal
      for (i = 0; i < N_CMP; i++) begin
         ta = rand_vec();
         tb = rand_vec();
         eq_lanes = LANES'($urandom);
         for (l = 0; l < LANES; l++) begin
            if (eq_lanes[l]) begin
               tb[l*DW +: DW] = ta[l*DW +: DW];
            end
         end
         send("sltu_seq", alu_op_e'(2 + i % 2), ta, tb, '1, 1'b0);
      end
      idle(4);

      for (i = 0; i < N_MASK; i++) begin
         send("mask", alu_op_e'($urandom_range(3, 0)), rand_vec(), rand_vec(),
              LANES'($urandom), 1'b0);
      end
      idle(4);

      for (i = 0; i < N_BC; i++) begin
         send("broadcast", alu_op_e'($urandom_range(3, 0)), rand_vec(), rand_vec(),
              '1, 1'b1);
      end
      idle(4);

      // a new request every cycle broken by short random gaps
      for (i = 0; i < N_B2B; i++) begin
         send("back_to_back", alu_op_e'($urandom_range(3, 0)), rand_vec(), rand_vec(),
              LANES'($urandom), 1'($urandom_range(1, 0)));
         if ($urandom_range(3, 0) == 0) begin
            idle($urandom_range(3, 1));
         end
      end
      idle(1);
      wait (exp_q.size() == 0);
      idle(4);

      total = res_errs + carry_errs + zero_errs + timing_errs;
      $display("errors: res %0d carry %0d zero %0d timing %0d",
               res_errs, carry_errs, zero_errs, timing_errs);
      if (total == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // outputs are registered and stable at the falling edge
   always @(negedge clk) begin
      logic [EW-1:0] exp;
      string         t_name;
      int            due;
      if (rst_q) begin
         assert (!out_valid) else begin
            $display("valid_o is high after a reset edge");
            timing_errs++;
         end
      end else if (out_valid) begin
         if (exp_q.size() == 0) begin
            $display("unexpected output: valid_o high with no request pending, cycle %0d",
                     cyc);
            timing_errs++;
         end else begin
            exp    = exp_q.pop_front();
            due    = due_q.pop_front();
            t_name = name_q.pop_front();
            assert (cyc == due) else begin
               $display("Error %s: valid_o cycle expected %0d actual %0d", t_name, due, cyc);
               timing_errs++;
            end
            assert (res == exp[EW-1 -: VW]) else begin
               $display("Error %s: res_o expected %h actual %h", t_name, exp[EW-1 -: VW], res);
               res_errs++;
            end
            assert (carry == exp[2*LANES-1 -: LANES]) else begin
               $display("Error %s: carry_o expected %b actual %b", t_name,
                        exp[2*LANES-1 -: LANES], carry);
               carry_errs++;
            end
            assert (zero == exp[LANES-1:0]) else begin
               $display("Error %s: zero_o expected %b actual %b", t_name,
                        exp[LANES-1:0], zero);
               zero_errs++;
            end
         end
      end else begin
         assert (carry == '0 && zero == '0) else begin
            $display("carry_o or zero_o is set while valid_o is low");
            timing_errs++;
         end
      end
   end

   initial begin
      #(LIMIT_CYC * 10);
      $display("timeout: run did not finish within %0d cycles", LIMIT_CYC);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire
